//--- verilog/viaBusPkg.sv
//////////////////////////////////////////////////////////////////////
// Host bus types for the cut-down 6522 VIA.
// Holds the data byte and register select types, the register map
// and the request struct that the host drives each bus cycle.
//////////////////////////////////////////////////////////////////////

package viaBusPkg;

	typedef logic [7:0] viaByteT;  // one data byte on the host bus.
	typedef logic [3:0] regAddrT;  // register select, RS3..RS0.

	// register map, as seen by the 6502 side.
	localparam regAddrT REG_ORB    = 4'h0;
	localparam regAddrT REG_ORA    = 4'h1;
	localparam regAddrT REG_DDRB   = 4'h2;
	localparam regAddrT REG_DDRA   = 4'h3;
	localparam regAddrT REG_T1CL   = 4'h4;
	localparam regAddrT REG_T1CH   = 4'h5;
	localparam regAddrT REG_T1LL   = 4'h6;
	localparam regAddrT REG_T1LH   = 4'h7;
	localparam regAddrT REG_ACR    = 4'hB;
	localparam regAddrT REG_PCR    = 4'hC;
	localparam regAddrT REG_IFR    = 4'hD;
	localparam regAddrT REG_IER    = 4'hE;
	localparam regAddrT REG_ORA_NH = 4'hF;  // port A without handshake.

	// One bus cycle as the host presents it.
	// The chip is selected with cs1 high and nCs2 low.
	typedef struct packed {
		logic    cs1;
		logic    nCs2;
		logic    rnw;     // high for a read, low for a write.
		regAddrT rs;
		viaByteT wrData;
	} busReqT;

endpackage

//--- verilog/viaCtrlPkg.sv
//////////////////////////////////////////////////////////////////////
// Internal control types for the cut-down 6522 VIA.
// Holds the interrupt flag layout, timer width, line filter depth
// and the decoded strobe struct passed from the register decoder.
//////////////////////////////////////////////////////////////////////

package viaCtrlPkg;

	typedef logic [6:0]  irqBitsT;  // IFR and IER, bit 7 excluded.
	typedef logic [15:0] counterT;  // timer 1 counter and latch.

	// flag positions inside IFR and IER.
	localparam int IRQ_CA2 = 0;
	localparam int IRQ_CA1 = 1;
	localparam int IRQ_CB2 = 3;
	localparam int IRQ_CB1 = 4;
	localparam int IRQ_T1  = 6;

	// Number of clkEn samples a control line must hold its level.
	localparam int FILTER_DEPTH = 4;

	// Decoded access for one cycle. Every strobe already includes the
	// chip select and clkEn, so it lasts exactly one enabled clock.
	typedef struct packed {
		logic               wrIfr;
		logic               wrIer;
		logic               wrT1High;
		logic               rdT1Low;
		logic               rdPortA;
		logic               rdPortB;
		viaBusPkg::regAddrT rs;
		logic               sel;       // chip selected for a read.
	} regStrobesT;

endpackage

//--- verilog/viaRegDecode.sv
//////////////////////////////////////////////////////////////////////
// Register decoder of the VIA. Turns host bus cycles into one-cycle
// strobes and holds the port, direction, control and latch registers.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module viaRegDecode (
	input  logic                   clk,
	input  logic                   nRESET,
	input  logic                   clkEn,
	input  viaBusPkg::busReqT      bus,
	output viaCtrlPkg::regStrobesT strobes,
	output viaBusPkg::viaByteT     outA,
	output viaBusPkg::viaByteT     outB,
	output viaBusPkg::viaByteT     ddrA,
	output viaBusPkg::viaByteT     ddrB,
	output viaBusPkg::viaByteT     pcr,
	output viaBusPkg::viaByteT     acr,
	output viaCtrlPkg::counterT    t1Latch
);

	logic chipSel;
	logic wrEn;
	logic rdEn;

	assign chipSel = bus.cs1 & ~bus.nCs2;
	assign wrEn = chipSel & ~bus.rnw & clkEn;
	assign rdEn = chipSel & bus.rnw & clkEn;

	always_comb begin
		strobes = '0;
		strobes.rs = bus.rs;
		strobes.sel = chipSel & bus.rnw;  // reads are not tied to clkEn.
		strobes.wrIfr = wrEn && (bus.rs == viaBusPkg::REG_IFR);
		strobes.wrIer = wrEn && (bus.rs == viaBusPkg::REG_IER);
		strobes.wrT1High = wrEn && (bus.rs == viaBusPkg::REG_T1CH);
		strobes.rdT1Low = rdEn && (bus.rs == viaBusPkg::REG_T1CL);
		strobes.rdPortA = rdEn && (bus.rs == viaBusPkg::REG_ORA ||
			bus.rs == viaBusPkg::REG_ORA_NH);
		strobes.rdPortB = rdEn && (bus.rs == viaBusPkg::REG_ORB);
	end

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			outA <= '0;
			outB <= '0;
			ddrA <= '0;  // all pins start as inputs.
			ddrB <= '0;
			pcr <= '0;
			acr <= '0;
		end else if (wrEn) begin
			case (bus.rs)
				viaBusPkg::REG_ORB: outB <= bus.wrData;
				viaBusPkg::REG_ORA,
				viaBusPkg::REG_ORA_NH: outA <= bus.wrData;
				viaBusPkg::REG_DDRB: ddrB <= bus.wrData;
				viaBusPkg::REG_DDRA: ddrA <= bus.wrData;
				viaBusPkg::REG_ACR: acr <= bus.wrData;  // stored only.
				viaBusPkg::REG_PCR: pcr <= bus.wrData;
				default: ;
			endcase
		end
	end

	// T1 low and latch low share the low latch byte.
	always_ff @(posedge clk) begin
		if (wrEn) begin
			case (bus.rs)
				viaBusPkg::REG_T1CL,
				viaBusPkg::REG_T1LL: t1Latch[7:0] <= bus.wrData;
				viaBusPkg::REG_T1LH: t1Latch[15:8] <= bus.wrData;
				default: ;
			endcase
		end
	end

endmodule

//--- verilog/viaLineSense.sv
//////////////////////////////////////////////////////////////////////
// Control line sensing for CA1, CA2, CB1 and CB2. Each line passes a
// shift filter and requests an interrupt at the level set in PCR.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module viaLineSense (
	input  logic                clk,
	input  logic                nRESET,
	input  logic                clkEn,
	input  logic                ca1,
	input  logic                ca2,
	input  logic                cb1,
	input  logic                cb2,
	input  viaBusPkg::viaByteT  pcr,
	input  viaCtrlPkg::irqBitsT clearMask,
	output logic [3:0]          lineIrq
);

	logic [3:0] lines;
	logic [3:0] polarity;
	logic [3:0] lineClear;
	logic [viaCtrlPkg::FILTER_DEPTH-1:0] filter [4];

	// index order is CA1, CA2, CB1, CB2 from bit 0 upwards.
	assign lines = {cb2, cb1, ca2, ca1};
	assign polarity = {pcr[6], pcr[4], pcr[2], pcr[0]};  // 1 means active high.
	assign lineClear = {clearMask[viaCtrlPkg::IRQ_CB2], clearMask[viaCtrlPkg::IRQ_CB1],
		clearMask[viaCtrlPkg::IRQ_CA2], clearMask[viaCtrlPkg::IRQ_CA1]};

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			for (int i = 0; i < 4; i++) begin
				filter[i] <= '1;  // idle lines rest high.
			end
		end else if (clkEn) begin
			for (int i = 0; i < 4; i++) begin
				filter[i] <= {filter[i][viaCtrlPkg::FILTER_DEPTH-2:0], lines[i]};
			end
		end
	end

	// A request needs every sample at the active level.
	always_ff @(posedge clk) begin
		if (!nRESET) begin
			lineIrq <= '0;
		end else begin
			for (int i = 0; i < 4; i++) begin
				lineIrq[i] <= (polarity[i] ? &filter[i] : ~|filter[i]) & ~lineClear[i];
			end
		end
	end

endmodule

//--- verilog/viaTimer1.sv
//////////////////////////////////////////////////////////////////////
// Timer 1 in continuous mode. A write to T1 high loads and arms the
// counter, which then counts down on clkEn and reloads from the latch
// each time it reaches zero, pulsing t1Zero for the flag logic.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module viaTimer1 (
	input  logic                   clk,
	input  logic                   nRESET,
	input  logic                   clkEn,
	input  viaCtrlPkg::regStrobesT strobes,
	input  viaBusPkg::viaByteT     wrData,
	input  viaCtrlPkg::counterT    t1Latch,
	output viaCtrlPkg::counterT    t1Count,
	output logic                   t1Zero
);

	logic armed;
	logic atZero;

	assign atZero = (t1Count == '0);

	// One pulse per reload edge; a fresh load takes priority.
	assign t1Zero = armed & atZero & clkEn & ~strobes.wrT1High;

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			armed <= 1'b0;
		end else if (strobes.wrT1High) begin
			armed <= 1'b1;  // stays armed, the mode is free running.
		end
	end

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			t1Count <= '0;
		end else if (strobes.wrT1High) begin
			// The high byte comes straight from the bus.
			t1Count <= {wrData, t1Latch[7:0]};
		end else if (clkEn && armed) begin
			if (atZero) begin
				t1Count <= t1Latch;
			end else begin
				t1Count <= t1Count - 1'b1;
			end
		end
	end

endmodule

//--- verilog/viaReadIrq.sv
//////////////////////////////////////////////////////////////////////
// Read data and interrupt logic of the VIA. Owns IFR and IER, builds
// the read multiplexer and registers the active-low interrupt pin.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module viaReadIrq (
	input  logic                   clk,
	input  logic                   nRESET,
	input  logic                   clkEn,
	input  viaCtrlPkg::regStrobesT strobes,
	input  viaBusPkg::viaByteT     wrData,
	input  viaBusPkg::viaByteT     outA,
	input  viaBusPkg::viaByteT     outB,
	input  viaBusPkg::viaByteT     ddrA,
	input  viaBusPkg::viaByteT     ddrB,
	input  viaBusPkg::viaByteT     pcr,
	input  viaBusPkg::viaByteT     acr,
	input  viaCtrlPkg::counterT    t1Latch,
	input  viaCtrlPkg::counterT    t1Count,
	input  viaBusPkg::viaByteT     portAIn,
	input  viaBusPkg::viaByteT     portBIn,
	input  logic [3:0]             lineIrq,
	input  logic                   t1Zero,
	output viaBusPkg::viaByteT     rdData,
	output viaCtrlPkg::irqBitsT    clearMask,
	output logic                   nIrq
);

	viaCtrlPkg::irqBitsT ifr;
	viaCtrlPkg::irqBitsT ier;
	viaCtrlPkg::irqBitsT setBits;
	viaBusPkg::viaByteT portAVal;
	viaBusPkg::viaByteT portBVal;
	logic anyIrq;

	// Output register where DDR is 1, pin where it is 0.
	assign portAVal = (outA & ddrA) | (portAIn & ~ddrA);
	assign portBVal = (outB & ddrB) | (portBIn & ~ddrB);
	assign anyIrq = |(ifr & ier);

	always_comb begin
		setBits = '0;
		setBits[viaCtrlPkg::IRQ_CA1] = lineIrq[0];
		setBits[viaCtrlPkg::IRQ_CA2] = lineIrq[1];
		setBits[viaCtrlPkg::IRQ_CB1] = lineIrq[2];
		setBits[viaCtrlPkg::IRQ_CB2] = lineIrq[3];
		setBits[viaCtrlPkg::IRQ_T1] = t1Zero;
	end

	// Flags cleared this cycle. The line sensor masks the same bits.
	always_comb begin
		clearMask = strobes.wrIfr ? wrData[6:0] : '0;
		if (strobes.rdPortA) begin
			clearMask[viaCtrlPkg::IRQ_CA1] = 1'b1;
			clearMask[viaCtrlPkg::IRQ_CA2] = 1'b1;
		end
		if (strobes.rdPortB) begin
			clearMask[viaCtrlPkg::IRQ_CB1] = 1'b1;
			clearMask[viaCtrlPkg::IRQ_CB2] = 1'b1;
		end
		if (strobes.rdT1Low || strobes.wrT1High) begin
			clearMask[viaCtrlPkg::IRQ_T1] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			ifr <= '0;
			ier <= '0;
		end else if (clkEn) begin
			ifr <= (ifr | setBits) & ~clearMask;  // a clear beats a set.
			if (strobes.wrIer) begin
				ier <= wrData[7] ? (ier | wrData[6:0]) : (ier & ~wrData[6:0]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			nIrq <= 1'b1;
		end else begin
			nIrq <= ~anyIrq;  // follows the flags even with clkEn low.
		end
	end

	always_comb begin
		rdData = '0;
		if (strobes.sel) begin
			case (strobes.rs)
				viaBusPkg::REG_ORB: rdData = portBVal;
				viaBusPkg::REG_ORA,
				viaBusPkg::REG_ORA_NH: rdData = portAVal;
				viaBusPkg::REG_DDRB: rdData = ddrB;
				viaBusPkg::REG_DDRA: rdData = ddrA;
				viaBusPkg::REG_T1CL: rdData = t1Count[7:0];
				viaBusPkg::REG_T1CH: rdData = t1Count[15:8];
				viaBusPkg::REG_T1LL: rdData = t1Latch[7:0];
				viaBusPkg::REG_T1LH: rdData = t1Latch[15:8];
				viaBusPkg::REG_ACR: rdData = acr;
				viaBusPkg::REG_PCR: rdData = pcr;
				viaBusPkg::REG_IFR: rdData = {anyIrq, ifr};
				viaBusPkg::REG_IER: rdData = {1'b1, ier};
				default: rdData = '0;
			endcase
		end
	end

endmodule

//--- verilog/via6522.sv
//////////////////////////////////////////////////////////////////////
// Top level of the cut-down 6522 VIA. Connects the register decoder,
// line sensing, timer 1 and the read and interrupt block. Port pins
// appear as separate in, out and output-enable vectors.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module via6522 (
	input  logic               clk,
	input  logic               nRESET,
	input  logic               clkEn,
	input  viaBusPkg::busReqT  bus,
	output viaBusPkg::viaByteT rdData,
	input  viaBusPkg::viaByteT portAIn,
	output viaBusPkg::viaByteT portAOut,
	output viaBusPkg::viaByteT portAOe,
	input  viaBusPkg::viaByteT portBIn,
	output viaBusPkg::viaByteT portBOut,
	output viaBusPkg::viaByteT portBOe,
	input  logic               ca1,
	input  logic               ca2,
	input  logic               cb1,
	input  logic               cb2,
	output logic               nIrq
);

	viaCtrlPkg::regStrobesT strobes;
	viaBusPkg::viaByteT outA;
	viaBusPkg::viaByteT outB;
	viaBusPkg::viaByteT ddrA;
	viaBusPkg::viaByteT ddrB;
	viaBusPkg::viaByteT pcr;
	viaBusPkg::viaByteT acr;
	viaCtrlPkg::counterT t1Latch;
	viaCtrlPkg::counterT t1Count;
	viaCtrlPkg::irqBitsT clearMask;
	logic [3:0] lineIrq;
	logic t1Zero;

	assign portAOut = outA;
	assign portBOut = outB;
	assign portAOe = ddrA;  // a DDR bit of 1 drives the pin.
	assign portBOe = ddrB;

	viaRegDecode decode (.clk, .nRESET, .clkEn, .bus, .strobes,
		.outA, .outB, .ddrA, .ddrB, .pcr, .acr, .t1Latch);

	viaLineSense lineSense (.clk, .nRESET, .clkEn, .ca1, .ca2, .cb1, .cb2,
		.pcr, .clearMask, .lineIrq);

	viaTimer1 timer1 (.clk, .nRESET, .clkEn, .strobes, .wrData(bus.wrData),
		.t1Latch, .t1Count, .t1Zero);

	viaReadIrq readIrq (.clk, .nRESET, .clkEn, .strobes, .wrData(bus.wrData),
		.outA, .outB, .ddrA, .ddrB, .pcr, .acr, .t1Latch, .t1Count,
		.portAIn, .portBIn, .lineIrq, .t1Zero, .rdData, .clearMask, .nIrq);

endmodule

//--- test/viaIrq_assertions.sv
//////////////////////////////////////////////////////////////////////
// Concurrent checks on the VIA interrupt block, bound into
// viaReadIrq. Counts its own failures for the testbench to see.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module viaIrqAssertions (
	input logic                   clk,
	input logic                   nRESET,
	input viaCtrlPkg::regStrobesT strobes,
	input viaBusPkg::viaByteT     wrData,
	input viaCtrlPkg::irqBitsT    ifr,
	input viaCtrlPkg::irqBitsT    ier,
	input logic                   nIrq
);

	int failCount = 0;

	resetIrqHigh: assert property (@(posedge clk) !nRESET |=> nIrq)
		else begin failCount++; $error("nIrq low during reset"); end

	// a line flag cleared through IFR stays clear one clock later too, as its request is masked.
	flagClear: assert property (@(posedge clk) disable iff (!nRESET)
		$past(strobes.wrIfr, 2) |->
		((ifr & $past(wrData[6:0], 2)) & ~(7'd1 << viaCtrlPkg::IRQ_T1)) == '0)
		else begin failCount++; $error("flag set while being cleared"); end

	irqFallCause: assert property (@(posedge clk) disable iff (!nRESET)
		$fell(nIrq) |-> $past(|(ifr & ier)))
		else begin failCount++; $error("nIrq fell without enabled flag"); end

endmodule

bind viaReadIrq viaIrqAssertions irqChecks (.*);

//--- test/tbVia.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the cut-down 6522 VIA. Drives bus cycles with a random
// clkEn, keeps a shadow model of the registers and checks every read,
// the port pins, the control line and timer flags and nIrq.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tbVia;

	localparam int B1_OPS = 16;
	localparam int B2_OPS = 8 * 9 + 10;
	localparam int B3_OPS = 4 * 40;
	localparam int B4_OPS = 40;
	localparam int CYCLES_PER_OP = 24;
	localparam int WATCHDOG_NS = (10 + (B1_OPS + B2_OPS + B3_OPS + B4_OPS) * CYCLES_PER_OP) * 10;
	localparam logic [3:0] LINE_POL = 4'b1010;  // CA2 and CB2 active high.

	logic clk = 1'b0;
	logic nRESET, clkEn, ca1, ca2, cb1, cb2, nIrq;
	viaBusPkg::busReqT bus;
	viaBusPkg::viaByteT rdData, portAIn, portBIn, portAOut, portAOe, portBOut, portBOe;

	// shadow state of the model.
	viaBusPkg::viaByteT outAM, outBM, ddrAM, ddrBM, pcrM, acrM;
	viaCtrlPkg::counterT latchM;
	viaCtrlPkg::irqBitsT ifrM, ierM;
	logic [31:0] rngState = 32'hb6f1275e;
	viaBusPkg::viaByteT gotRd, expRd;
	event readDone;

	via6522 uut (.clk, .nRESET, .clkEn, .bus, .rdData, .portAIn, .portAOut, .portAOe,
		.portBIn, .portBOut, .portBOe, .ca1, .ca2, .cb1, .cb2, .nIrq);

	always #5 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		return s ^ (s << 5);
	endfunction

	function automatic logic [31:0] nextRand();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	// Expected read data from the shadow registers.
	function automatic viaBusPkg::viaByteT expectedRead(input viaBusPkg::regAddrT rs);
		case (rs)
			viaBusPkg::REG_ORB: return (outBM & ddrBM) | (portBIn & ~ddrBM);
			viaBusPkg::REG_ORA, viaBusPkg::REG_ORA_NH: return (outAM & ddrAM) | (portAIn & ~ddrAM);
			viaBusPkg::REG_DDRB: return ddrBM;
			viaBusPkg::REG_DDRA: return ddrAM;
			viaBusPkg::REG_T1LL: return latchM[7:0];
			viaBusPkg::REG_T1LH: return latchM[15:8];
			viaBusPkg::REG_ACR: return acrM;
			viaBusPkg::REG_PCR: return pcrM;
			viaBusPkg::REG_IFR: return {|(ifrM & ierM), ifrM};
			viaBusPkg::REG_IER: return {1'b1, ierM};
			default: return 8'h00;
		endcase
	endfunction

	task automatic stopOnError();
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkByte(input viaBusPkg::viaByteT got, input viaBusPkg::viaByteT exp,
		input string name);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			stopOnError();
		end
	endtask

	task automatic checkIrqBits(input viaCtrlPkg::irqBitsT got, input viaCtrlPkg::irqBitsT exp,
		input string name);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			stopOnError();
		end
	endtask

	task automatic checkCount(input viaCtrlPkg::counterT got, input viaCtrlPkg::counterT exp,
		input string name);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			stopOnError();
		end
	endtask

	task automatic checkPin(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			stopOnError();
		end
	endtask

	always @(readDone) checkByte(gotRd, expRd, "rdData");

	// one clock, then drive the next clkEn shortly after the edge.
	task automatic nextCycle();
		logic [31:0] r;
		@(posedge clk);
		#1;
		r = nextRand();
		clkEn = (r[1:0] != 2'b00);
	endtask

	task automatic waitEnabled(input int n);
		int seen;
		seen = 0;
		while (seen < n) begin
			if (clkEn) seen++;
			nextCycle();
		end
	endtask

	task automatic busIdle();
		bus = '0;
		bus.nCs2 = 1'b1;
		bus.rnw = 1'b1;
	endtask

	task automatic writeReg(input viaBusPkg::regAddrT rs, input viaBusPkg::viaByteT d);
		bus = '{cs1: 1'b1, nCs2: 1'b0, rnw: 1'b0, rs: rs, wrData: d};
		while (!clkEn) nextCycle();
		nextCycle();
		busIdle();
		case (rs)
			viaBusPkg::REG_ORB: outBM = d;
			viaBusPkg::REG_ORA, viaBusPkg::REG_ORA_NH: outAM = d;
			viaBusPkg::REG_DDRB: ddrBM = d;
			viaBusPkg::REG_DDRA: ddrAM = d;
			viaBusPkg::REG_T1CL, viaBusPkg::REG_T1LL: latchM[7:0] = d;
			viaBusPkg::REG_T1LH: latchM[15:8] = d;
			viaBusPkg::REG_T1CH: ifrM[viaCtrlPkg::IRQ_T1] = 1'b0;
			viaBusPkg::REG_ACR: acrM = d;
			viaBusPkg::REG_PCR: pcrM = d;
			viaBusPkg::REG_IFR: ifrM = ifrM & ~d[6:0];
			viaBusPkg::REG_IER: ierM = d[7] ? (ierM | d[6:0]) : (ierM & ~d[6:0]);
			default: ;
		endcase
	endtask

	task automatic readReg(input viaBusPkg::regAddrT rs, input bit doCheck,
		output viaBusPkg::viaByteT data);
		bus = '{cs1: 1'b1, nCs2: 1'b0, rnw: 1'b1, rs: rs, wrData: 8'h00};
		while (!clkEn) nextCycle();
		#1;
		data = rdData;
		if (doCheck) begin
			gotRd = data;
			expRd = expectedRead(rs);
			->readDone;
		end
		nextCycle();  // the read side effects happen on this edge.
		busIdle();
		if (rs == viaBusPkg::REG_ORA || rs == viaBusPkg::REG_ORA_NH) begin
			ifrM[viaCtrlPkg::IRQ_CA1] = 1'b0;
			ifrM[viaCtrlPkg::IRQ_CA2] = 1'b0;
		end else if (rs == viaBusPkg::REG_ORB) begin
			ifrM[viaCtrlPkg::IRQ_CB1] = 1'b0;
			ifrM[viaCtrlPkg::IRQ_CB2] = 1'b0;
		end else if (rs == viaBusPkg::REG_T1CL) begin
			ifrM[viaCtrlPkg::IRQ_T1] = 1'b0;
		end
	endtask

	task automatic waitIrqLow(input int limit);
		int seen;
		seen = 0;
		while (nIrq !== 1'b0) begin
			if (clkEn) seen++;
			if (seen > limit) begin
				$display("nIrq did not go low within %0d enabled cycles", limit);
				stopOnError();
			end
			nextCycle();
		end
	endtask

	task automatic settleIrq();
		nextCycle();
		checkPin(nIrq, ~|(ifrM & ierM), "nIrq");
	endtask

	task automatic setLine(input int idx, input logic v);
		case (idx)
			0: ca1 = v;
			1: ca2 = v;
			2: cb1 = v;
			default: cb2 = v;
		endcase
	endtask

	function automatic int lineFlag(input int idx);
		case (idx)
			0: return viaCtrlPkg::IRQ_CA1;
			1: return viaCtrlPkg::IRQ_CA2;
			2: return viaCtrlPkg::IRQ_CB1;
			default: return viaCtrlPkg::IRQ_CB2;
		endcase
	endfunction

	initial begin
		#WATCHDOG_NS;
		$display("watchdog expired before the tests finished");
		stopOnError();
	end

	initial begin
		viaBusPkg::viaByteT d, lo, hi;
		logic [31:0] r;
		int flag;
		nRESET = 1'b0;
		clkEn = 1'b0;
		busIdle();
		portAIn = 8'h00;
		portBIn = 8'h00;
		{ca1, ca2, cb1, cb2} = 4'b1111;
		{outAM, outBM, ddrAM, ddrBM, pcrM, acrM} = '0;
		latchM = '0;
		ifrM = '0;
		ierM = '0;
		repeat (10) nextCycle();
		nRESET = 1'b1;
		settleIrq();

		// register write and readback.
		for (int i = 0; i < 2; i++) begin
			r = nextRand();
			writeReg(viaBusPkg::REG_DDRA, r[7:0]);
			writeReg(viaBusPkg::REG_DDRB, r[15:8]);
			writeReg(viaBusPkg::REG_ACR, r[23:16]);
			writeReg(viaBusPkg::REG_PCR, r[31:24]);
			r = nextRand();
			writeReg(viaBusPkg::REG_T1LL, r[7:0]);
			writeReg(viaBusPkg::REG_T1LH, r[15:8]);
			readReg(viaBusPkg::REG_DDRA, 1, d);
			readReg(viaBusPkg::REG_DDRB, 1, d);
			readReg(viaBusPkg::REG_ACR, 1, d);
			readReg(viaBusPkg::REG_PCR, 1, d);
			readReg(viaBusPkg::REG_T1LL, 0, lo);
			readReg(viaBusPkg::REG_T1LH, 0, hi);
			checkCount({hi, lo}, latchM, "t1Latch");
		end

		// port mixing of output register and pins.
		for (int i = 0; i < 8; i++) begin
			r = nextRand();
			writeReg(viaBusPkg::REG_ORA, r[7:0]);
			writeReg(viaBusPkg::REG_ORB, r[15:8]);
			writeReg(viaBusPkg::REG_DDRA, r[23:16]);
			writeReg(viaBusPkg::REG_DDRB, r[31:24]);
			r = nextRand();
			portAIn = r[7:0];
			portBIn = r[15:8];
			checkByte(portAOut, outAM, "portAOut");
			checkByte(portBOut, outBM, "portBOut");
			checkByte(portAOe, ddrAM, "portAOe");
			checkByte(portBOe, ddrBM, "portBOe");
			readReg(r[16] ? viaBusPkg::REG_ORA : viaBusPkg::REG_ORA_NH, 1, d);
			readReg(viaBusPkg::REG_ORB, 1, d);
			checkPin(nIrq, 1'b1, "nIrq");
		end

		// IER set and clear rule.
		r = nextRand();
		writeReg(viaBusPkg::REG_IER, {1'b1, r[6:0]});
		readReg(viaBusPkg::REG_IER, 1, d);
		writeReg(viaBusPkg::REG_IER, {1'b0, r[14:8]});
		readReg(viaBusPkg::REG_IER, 1, d);
		writeReg(viaBusPkg::REG_IER, 8'h7F);
		readReg(viaBusPkg::REG_IER, 1, d);

		// control lines, each at its own polarity.
		{cb2, cb1, ca2, ca1} = ~LINE_POL;
		writeReg(viaBusPkg::REG_PCR, 8'h44);
		waitEnabled(viaCtrlPkg::FILTER_DEPTH + 2);
		writeReg(viaBusPkg::REG_IFR, 8'h7F);
		readReg(viaBusPkg::REG_IFR, 1, d);
		for (int i = 0; i < 4; i++) begin
			flag = lineFlag(i);
			writeReg(viaBusPkg::REG_IER, 8'h80 | (8'h01 << flag));
			settleIrq();
			setLine(i, LINE_POL[i]);
			waitIrqLow(viaCtrlPkg::FILTER_DEPTH + 4);
			ifrM[flag] = 1'b1;
			readReg(viaBusPkg::REG_IFR, 0, d);
			checkIrqBits(d[6:0], ifrM, "IFR");
			checkPin(d[7], |(ifrM & ierM), "IFR bit 7");
			setLine(i, ~LINE_POL[i]);
			waitEnabled(viaCtrlPkg::FILTER_DEPTH + 2);
			if (i % 2 == 0) begin
				readReg(i < 2 ? viaBusPkg::REG_ORA : viaBusPkg::REG_ORB, 1, d);
			end else begin
				writeReg(viaBusPkg::REG_IFR, 8'h01 << flag);
			end
			readReg(viaBusPkg::REG_IFR, 0, d);
			checkIrqBits(d[6:0], ifrM, "IFR");
			checkPin(d[7], |(ifrM & ierM), "IFR bit 7");
			settleIrq();
			writeReg(viaBusPkg::REG_IER, 8'h7F);
		end

		// timer 1 with a short latch.
		writeReg(viaBusPkg::REG_T1LL, 8'h05);
		writeReg(viaBusPkg::REG_T1LH, 8'h00);
		writeReg(viaBusPkg::REG_IER, 8'hC0);
		writeReg(viaBusPkg::REG_T1CH, 8'h00);
		waitIrqLow(5 + 4);
		ifrM[viaCtrlPkg::IRQ_T1] = 1'b1;
		readReg(viaBusPkg::REG_IFR, 1, d);
		readReg(viaBusPkg::REG_T1CL, 0, d);  // the count itself is not predicted.
		readReg(viaBusPkg::REG_IFR, 0, d);
		checkIrqBits(d[6:0], ifrM, "IFR");
		checkPin(d[7], |(ifrM & ierM), "IFR bit 7");
		waitIrqLow(5 + 4);
		ifrM[viaCtrlPkg::IRQ_T1] = 1'b1;
		readReg(viaBusPkg::REG_IFR, 1, d);
		writeReg(viaBusPkg::REG_IER, 8'h7F);
		settleIrq();

		nextCycle();
		if (uut.readIrq.irqChecks.failCount != 0) begin
			$display("%0d assertion failures seen", uut.readIrq.irqChecks.failCount);
			stopOnError();
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

//--- sources.f
verilog/viaBusPkg.sv
verilog/viaCtrlPkg.sv
verilog/viaRegDecode.sv
verilog/viaLineSense.sv
verilog/viaTimer1.sv
verilog/viaReadIrq.sv
verilog/via6522.sv
test/viaIrq_assertions.sv
test/tbVia.sv

//--- Makefile
TOOL     = verilator
TOP      = tbVia
FILELIST = sources.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
